/* src.f */
+incdir+include
rtl/dot_pkg.sv
rtl/sync_fifo.sv
rtl/dot_unit.sv
rtl/dot_top.sv
verif/dot_tb.sv

/* verif/dot_tb.sv */
`timescale 1ns/1ps

`include "dot_cfg.svh"

module dot_tb
    import dot_pkg::*;
();

    localparam int table_len = 8;
    localparam int rand_count = 200;
    localparam int fill_limit = `DOT_IN_DEPTH + 1 + `DOT_OUT_DEPTH;
    localparam int cycle_limit = (3 * table_len + rand_count) * 8 + 400;

    logic          clock;
    logic          reset;
    logic          in_wr_en;
    dot_operands_t in_data;
    logic          in_full;
    logic          out_rd_en;
    dot_result_t   out_data;
    logic          out_empty;

    dot_operands_t table_ops [table_len];
    dot_result_t   table_exp [table_len];
    dot_result_t   expected [$];

    int value_errors = 0;
    int other_errors = 0;
    int cycles = 0;
    int seed = 32'h55fc;

    dot_top DUT (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_data   (in_data),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_data  (out_data),
        .out_empty (out_empty)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    // each product is scaled on its own, then the sum keeps its low word
    function automatic dot_result_t dot_model(dot_operands_t ops);
        longint sum;
        sum = 0;
        sum += (longint'(ops.x.c0) * longint'(ops.y.c0)) >>> `DOT_Q_BITS;
        sum += (longint'(ops.x.c1) * longint'(ops.y.c1)) >>> `DOT_Q_BITS;
        sum += (longint'(ops.x.c2) * longint'(ops.y.c2)) >>> `DOT_Q_BITS;
        return sum[31:0];
    endfunction

    function automatic dot_operands_t make_pair(dot_word_t x0, dot_word_t x1, dot_word_t x2,
                                                dot_word_t y0, dot_word_t y1, dot_word_t y2);
        dot_operands_t ops;
        ops.x = '{c2: x2, c1: x1, c0: x0};
        ops.y = '{c2: y2, c1: y1, c0: y0};
        return ops;
    endfunction

    // Q10 values, so 1024 is 1.0
    task automatic load_table();
        table_ops[0] = make_pair(1024, 2048, 3072, 4096, 5120, 6144);
        table_exp[0] = 32'h0000_8000;
        table_ops[1] = make_pair(-1536, 2304, -512, 2048, -4096, 8192);
        table_exp[1] = 32'hffff_c000;
        table_ops[2] = make_pair(0, 0, 0, 12345, -999, 77);
        table_exp[2] = 32'h0000_0000;
        // products of 2^38, 2^36 and -2^40 before the shift
        table_ops[3] = make_pair(32'h0100_0000, 32'h0004_0000, 32'hfff0_0000,
                                 32'h0000_4000, 32'h0004_0000, 32'h0010_0000);
        table_exp[3] = 32'hd400_0000;
        table_ops[4] = make_pair(32'h8000_0000, 0, 0, 32'h7fff_ffff, 0, 0);
        table_exp[4] = 32'h0020_0000;
        // tiny negative products round toward minus infinity
        table_ops[5] = make_pair(-1, 3, -1000, 1, 5, 1);
        table_exp[5] = 32'hffff_fffe;
        table_ops[6] = make_pair(32'h7fff_ffff, 32'h7fff_ffff, 32'h7fff_ffff,
                                 32'h7fff_ffff, 32'h7fff_ffff, 32'h7fff_ffff);
        table_exp[6] = 32'hff40_0000;
        table_ops[7] = make_pair(768, -3072, 102912, -2048, -256, 128);
        table_exp[7] = 32'h0000_2f40;
    endtask

    task automatic check_result(input string name, input dot_result_t exp,
                                input dot_result_t act);
        if (act !== exp) begin
            value_errors++;
            $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            value_errors++;
            $display("ERROR %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    // one clock of traffic, with the inputs changed 5 ns after the edge
    task automatic cycle_io(input logic want_wr, input dot_operands_t ops,
                            input dot_result_t exp, input logic want_rd, output logic accepted);
        @(posedge clock);
        #5;
        if (want_rd && !out_empty) begin
            if (expected.size() == 0) begin
                other_errors++;
                $display("a result showed up at %0t with no operand pair outstanding", $time);
            end else begin
                check_result("out_data", expected.pop_front(), out_data);
            end
            out_rd_en = 1'b1;
        end else begin
            out_rd_en = 1'b0;
        end
        accepted = want_wr && !in_full;
        in_wr_en = accepted;
        if (accepted) begin
            in_data = ops;
            expected.push_back(exp);
        end
    endtask

    task automatic drain();
        logic acc;
        while (expected.size() > 0) begin
            cycle_io(1'b0, '0, '0, 1'b1, acc);
        end
        cycle_io(1'b0, '0, '0, 1'b0, acc);
    endtask

    task automatic random_pair(output dot_operands_t ops);
        logic [31:0] r;
        dot_word_t   w [6];
        r = $random(seed);
        for (int k = 0; k < 6; k++) begin
            w[k] = $random(seed);
            // keep some components small so the sum does not always wrap
            if (r[k]) begin
                w[k] = w[k] >>> 12;
            end
        end
        ops = make_pair(w[0], w[1], w[2], w[3], w[4], w[5]);
    endtask

    initial begin
        while (cycles <= cycle_limit) begin
            @(posedge clock);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int            i;
        int            n;
        int            full_run;
        logic          acc;
        logic [31:0]   r;
        dot_operands_t ops;
        reset = 1'b1;
        in_wr_en = 1'b0;
        in_data = '0;
        out_rd_en = 1'b0;
        load_table();
        repeat (8) @(posedge clock);
        #5;
        reset = 1'b0;
        check_flag("out_empty", 1'b1, out_empty);
        check_flag("in_full", 1'b0, in_full);

        // one pair at a time
        for (i = 0; i < table_len; i++) begin
            cycle_io(1'b1, table_ops[i], table_exp[i], 1'b0, acc);
            drain();
        end

        // back to back with continuous reads
        i = 0;
        while (i < table_len) begin
            cycle_io(1'b1, table_ops[i], table_exp[i], 1'b1, acc);
            if (acc) begin
                i++;
            end
        end
        drain();

        // with no reads the whole pipeline fills
        n = 0;
        full_run = 0;
        while (full_run < 4 && n <= 2 * fill_limit) begin
            cycle_io(1'b1, table_ops[n % table_len], table_exp[n % table_len], 1'b0, acc);
            if (acc) begin
                n++;
            end
            full_run = in_full ? full_run + 1 : 0;
        end
        check_count("accepted pairs", fill_limit, n);
        check_flag("in_full", 1'b1, in_full);
        drain();

        n = 0;
        while (n < rand_count) begin
            random_pair(ops);
            r = $random(seed);
            cycle_io(r[0] | r[1], ops, dot_model(ops), r[2], acc);
            if (acc) begin
                n++;
            end
        end
        drain();
        repeat (4) cycle_io(1'b0, '0, '0, 1'b0, acc);
        check_flag("out_empty", 1'b1, out_empty);
        check_flag("in_full", 1'b0, in_full);

        $display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* rtl/dot_top.sv */
`timescale 1ns/1ps

`include "dot_cfg.svh"

module dot_top
    import dot_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  logic          in_wr_en,
    input  dot_operands_t in_data,
    output logic          in_full,
    input  logic          out_rd_en,
    output dot_result_t   out_data,
    output logic          out_empty
);

    // operand FIFO to dot unit
    dot_operands_t op_data;
    logic          op_empty;
    logic          op_rd_en;

    // dot unit to result FIFO
    dot_result_t   res_data;
    logic          res_wr_en;
    logic          res_full;

    sync_fifo #(
        .width    ($bits(dot_operands_t)),
        .depth    (`DOT_IN_DEPTH)
    ) u_operand_fifo (
        .clock    (clock),
        .reset    (reset),
        .wr_en    (in_wr_en),
        .din      (in_data),
        .rd_en    (op_rd_en),
        .dout     (op_data),
        .full     (in_full),
        .empty    (op_empty)
    );

    dot_unit u_dot_unit (
        .clock     (clock),
        .reset     (reset),
        .operands  (op_data),
        .in_empty  (op_empty),
        .out_full  (res_full),
        .in_rd_en  (op_rd_en),
        .result    (res_data),
        .out_wr_en (res_wr_en)
    );

    sync_fifo #(
        .width    ($bits(dot_result_t)),
        .depth    (`DOT_OUT_DEPTH)
    ) u_result_fifo (
        .clock    (clock),
        .reset    (reset),
        .wr_en    (res_wr_en),
        .din      (res_data),
        .rd_en    (out_rd_en),
        .dout     (out_data),
        .full     (res_full),
        .empty    (out_empty)
    );

endmodule

/* rtl/dot_unit.sv */
`timescale 1ns/1ps

`include "dot_cfg.svh"

module dot_unit
    import dot_pkg::*;
(
    input  logic          clock,
    input  logic          reset,
    input  dot_operands_t operands,
    input  logic          in_empty,
    input  logic          out_full,
    output logic          in_rd_en,
    output dot_result_t   result,
    output logic          out_wr_en
);

    dot_state_t state;
    dot_state_t next_state;

    logic signed [`DOT_ACC_BITS-1:0] term [3];
    logic signed [`DOT_ACC_BITS-1:0] acc;
    dot_result_t                     result_next;

    // full 64-bit product, scaled back to the Q format and held at the
    // accumulation width
    function automatic logic signed [`DOT_ACC_BITS-1:0] scaled_product(
        dot_word_t a,
        dot_word_t b
    );
        logic signed [63:0] wide_a;
        logic signed [63:0] wide_b;
        logic signed [63:0] prod;
        wide_a = a;
        wide_b = b;
        prod = wide_a * wide_b;
        return `DOT_ACC_BITS'(prod >>> `DOT_Q_BITS);
    endfunction

    // the operand FIFO is show-ahead, so its head is valid whenever in_empty is low
    assign term[0] = scaled_product(operands.x.c0, operands.y.c0);
    assign term[1] = scaled_product(operands.x.c1, operands.y.c1);
    assign term[2] = scaled_product(operands.x.c2, operands.y.c2);

    assign acc = term[0] + term[1] + term[2];

    // no saturation, only the low word survives
    assign result_next = acc[$bits(dot_result_t)-1:0];

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // the result is captured on the same edge that pops the operand pair
    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            result <= result_next;
        end
    end

    always_comb begin
        next_state = state;
        in_rd_en = 1'b0;
        out_wr_en = 1'b0;
        case (state)
            IDLE: begin
                if (!in_empty) begin
                    in_rd_en = 1'b1;
                    next_state = HOLD;
                end
            end
            HOLD: begin
                // wait here for as long as the result FIFO is full
                if (!out_full) begin
                    out_wr_en = 1'b1;
                    next_state = IDLE;
                end
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // a result is pushed only while one is held
    assert property (@(posedge clock) disable iff (reset) out_wr_en |-> state == HOLD)
        else $error("dot_unit: out_wr_en outside HOLD");

    assert property (@(posedge clock) disable iff (reset) !(in_rd_en && in_empty))
        else $error("dot_unit: in_rd_en while the operand FIFO is empty");

endmodule

/* rtl/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int width = 32,
    parameter int depth = 4
) (
    input  logic             clock,
    input  logic             reset,
    input  logic             wr_en,
    input  logic [width-1:0] din,
    input  logic             rd_en,
    output logic [width-1:0] dout,
    output logic             full,
    output logic             empty
);

    localparam int ptr_bits = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_bits = $clog2(depth + 1);

    logic [width-1:0]      mem [depth];
    logic [ptr_bits-1:0]   wr_ptr;
    logic [ptr_bits-1:0]   rd_ptr;
    logic [count_bits-1:0] count;
    logic                  do_write;
    logic                  do_read;

    // pointers wrap at depth, which need not be a power of two
    function automatic logic [ptr_bits-1:0] next_ptr(logic [ptr_bits-1:0] ptr);
        logic [ptr_bits-1:0] nxt;
        if (ptr == ptr_bits'(depth - 1)) begin
            nxt = '0;
        end else begin
            nxt = ptr + 1'b1;
        end
        return nxt;
    endfunction

    assign full = (count == count_bits'(depth));
    assign empty = (count == '0);

    // a write while full and a read while empty are both ignored
    assign do_write = wr_en && !full;
    assign do_read = rd_en && !empty;

    // show-ahead, so the head entry is visible without a read
    assign dout = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_read) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the producer is expected to watch full
    assert property (@(posedge clock) disable iff (reset) !(wr_en && full))
        else $error("sync_fifo: write while full is dropped");

    // and the consumer to watch empty
    assert property (@(posedge clock) disable iff (reset) !(rd_en && empty))
        else $error("sync_fifo: read while empty is ignored");

endmodule

/* rtl/dot_pkg.sv */
package dot_pkg;

    // one fixed-point component, two's complement with the fraction in the low bits
    typedef logic signed [31:0] dot_word_t;

    // c2 sits in the high bits and c0 in the low bits
    typedef struct packed {
        dot_word_t c2;
        dot_word_t c1;
        dot_word_t c0;
    } vec3_t;

    // one FIFO entry on the input side holds both vectors
    typedef struct packed {
        vec3_t x;
        vec3_t y;
    } dot_operands_t;

    // the dot product after the low 32 bits of the sum are kept
    typedef logic signed [31:0] dot_result_t;

    // IDLE waits for an operand pair, HOLD waits for room in the result FIFO
    typedef enum logic {
        IDLE = 1'b0,
        HOLD = 1'b1
    } dot_state_t;

endpackage

/* include/dot_cfg.svh */
`ifndef DOT_CFG_SVH
`define DOT_CFG_SVH

// fraction bits of the Q format shared by operands and result
`define DOT_Q_BITS 10

// the three scaled products are summed at this width and the low word is kept
`define DOT_ACC_BITS 48

// entries in the operand FIFO and in the result FIFO
`define DOT_IN_DEPTH 4
`define DOT_OUT_DEPTH 4

`endif
